// File: ex_alu.sv
// Single-cycle ALU
`timescale 1ns/1ps

module ex_alu #(
  parameter int DATA_W = ex_pkg::DATA_W
) (
  input  ex_pkg::alu_op_e   op_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);
  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W-1:0]  sum;
  logic [DATA_W-1:0]  diff;
  logic [DATA_W-1:0]  sra_res;
  logic               eq;
  logic               lt_s;
  logic               lt_u;

  ////////////////////////////////////////
  // Shared arithmetic and compare
  ////////////////////////////////////////

  // Shift amount from low bits of B
  assign shamt = operand_b_i[SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Arithmetic shift kept apart so the signed cast stays local
  assign sra_res = $unsigned($signed(operand_a_i) >>> shamt);

  assign eq   = (operand_a_i == operand_b_i);
  assign lt_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u = (operand_a_i < operand_b_i);

  // Comparison result, also the branch decision
  always_comb begin
    case (op_i)
      ALU_SLT, ALU_LT:   cmp_result_o = lt_s;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_u;
      ALU_EQ:            cmp_result_o = eq;
      ALU_NE:            cmp_result_o = !eq;
      ALU_GE:            cmp_result_o = !lt_s;
      ALU_GEU:           cmp_result_o = !lt_u;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    case (op_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = sra_res;
      // SLT, SLTU and branch compares return the flag zero-extended
      default: result_o = {{(DATA_W-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: ex_div.sv
// Iterative restoring divider
`timescale 1ns/1ps

module ex_div #(
  parameter int DATA_W = ex_pkg::DATA_W
) (
  input logic clk,
  input logic rst_n,
  div_hs_if.div div_o
);
  import ex_pkg::*;

  localparam int CNT_W = $clog2(DATA_W);

  div_state_e        state;
  logic [CNT_W-1:0]  cnt;

  // Datapath registers
  logic [DATA_W-1:0] quot;
  logic [DATA_W-1:0] rem;
  logic [DATA_W-1:0] divisor;
  logic              neg_q;
  logic              neg_r;
  logic              is_rem;

  // Operand decode
  logic              op_signed;
  logic              sign_a;
  logic              sign_b;
  logic [DATA_W-1:0] mag_a;
  logic [DATA_W-1:0] mag_b;

  // One shift-subtract step
  logic [DATA_W:0]   rem_sh;
  logic              step_ge;
  logic [DATA_W:0]   rem_sub;

  assign op_signed = (div_o.op == DIV_DIV) || (div_o.op == DIV_REM);
  assign sign_a    = op_signed && div_o.op_a[DATA_W-1];
  assign sign_b    = op_signed && div_o.op_b[DATA_W-1];
  assign mag_a     = sign_a ? -div_o.op_a : div_o.op_a;
  assign mag_b     = sign_b ? -div_o.op_b : div_o.op_b;

  // Shift next dividend bit into partial remainder, then trial subtract
  assign rem_sh  = {rem, quot[DATA_W-1]};
  assign step_ge = (rem_sh >= {1'b0, divisor});
  assign rem_sub = rem_sh - {1'b0, divisor};

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (div_o.start) begin
            // Zero divisor needs no iterations
            state <= (div_o.op_b == '0) ? DIV_DONE : DIV_BUSY;
            cnt   <= CNT_W'(DATA_W - 1);
          end
        end
        DIV_BUSY: begin
          if (!div_o.active) begin
            state <= DIV_IDLE;
          end else if (cnt == '0) begin
            state <= DIV_DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        DIV_DONE: begin
          // Leave on hand-off or when the divide left EX
          if (div_o.accept || !div_o.active) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && div_o.start) begin
      is_rem  <= (div_o.op == DIV_REM) || (div_o.op == DIV_REMU);
      divisor <= mag_b;
      if (div_o.op_b == '0) begin
        // All-ones quotient, dividend as remainder, no sign fix
        quot  <= '1;
        rem   <= div_o.op_a;
        neg_q <= 1'b0;
        neg_r <= 1'b0;
      end else begin
        quot  <= mag_a;
        rem   <= '0;
        neg_q <= sign_a ^ sign_b;
        neg_r <= sign_a;
      end
    end else if (state == DIV_BUSY) begin
      quot <= {quot[DATA_W-2:0], step_ge};
      rem  <= step_ge ? rem_sub[DATA_W-1:0] : rem_sh[DATA_W-1:0];
    end
  end

  // Sign fix, MIN / -1 wraps back to MIN on its own
  assign div_o.result = is_rem ? (neg_r ? -rem : rem) : (neg_q ? -quot : quot);

  assign div_o.valid = (state == DIV_DONE);
  assign div_o.ready = ((state == DIV_IDLE) && !div_o.start) ||
                       ((state == DIV_DONE) && div_o.accept);

endmodule

// File: ex_if.sv
// Execute stage interfaces
`timescale 1ns/1ps

////////////////////////////////////////
// Divider handshake
////////////////////////////////////////
interface div_hs_if #(
  parameter int DATA_W = ex_pkg::DATA_W
);
  import ex_pkg::*;

  // Request side, from the datapath
  logic              start;
  logic              active;
  logic              accept;
  div_op_e           op;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;

  // Response side, from the divider
  logic              ready;
  logic              valid;
  logic [DATA_W-1:0] result;

  modport issue (
    output start, active, accept, op, op_a, op_b,
    input  ready, valid, result
  );

  modport div (
    input  start, active, accept, op, op_a, op_b,
    output ready, valid, result
  );
endinterface

////////////////////////////////////////
// Result towards EX/WB register
////////////////////////////////////////
interface ex_result_if #(
  parameter int DATA_W = ex_pkg::DATA_W
);
  import ex_pkg::*;

  logic                 valid;
  logic                 rf_we;
  logic [RF_ADDR_W-1:0] rf_waddr;
  logic [DATA_W-1:0]    rf_wdata;
  logic                 jmp;
  logic                 bch_taken;

  modport issue (output valid, rf_we, rf_waddr, rf_wdata, jmp, bch_taken);

  // Register side only samples
  modport wb (input valid, rf_we, rf_waddr, rf_wdata, jmp, bch_taken);
endinterface

// File: ex_issue.sv
// Execute datapath
`timescale 1ns/1ps

module ex_issue #(
  parameter int DATA_W = ex_pkg::DATA_W
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // From decode
  input  logic                         id_valid_i,
  input  logic                         alu_en_i,
  input  logic                         div_en_i,
  input  ex_pkg::alu_op_e              alu_op_i,
  input  ex_pkg::div_op_e              div_op_i,
  input  logic [DATA_W-1:0]            operand_a_i,
  input  logic [DATA_W-1:0]            operand_b_i,
  input  logic                         branch_i,
  input  logic                         jump_i,
  input  logic                         rf_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] rf_waddr_i,
  // From controller
  input  logic                         kill_i,
  input  logic                         halt_i,
  // From writeback
  input  logic                         wb_ready_i,
  // Stage handshake and forwarding
  output logic                         ex_ready_o,
  output logic                         ex_valid_o,
  output logic                         branch_decision_o,
  output logic [DATA_W-1:0]            rf_wdata_o,
  ex_result_if.issue                   res_o
);

  logic              instr_valid;
  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp;

  div_hs_if #(.DATA_W(DATA_W)) div_hs ();

  // Kill and halt suppress the instruction in EX
  assign instr_valid = id_valid_i && !kill_i && !halt_i;

  ////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////
  ex_alu #(.DATA_W(DATA_W)) u_alu (
    .op_i         (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Gated request, ungated presence for abort
  assign div_hs.start  = div_en_i && instr_valid;
  assign div_hs.active = div_en_i && id_valid_i;
  assign div_hs.accept = ex_valid_o && wb_ready_i;
  assign div_hs.op     = div_op_i;
  assign div_hs.op_a   = operand_a_i;
  assign div_hs.op_b   = operand_b_i;

  ex_div #(.DATA_W(DATA_W)) u_div (
    .clk   (clk),
    .rst_n (rst_n),
    .div_o (div_hs.div)
  );

  ////////////////////////////////////////
  // Result and stage handshake
  ////////////////////////////////////////

  // Forwarded to decode in the same cycle
  assign rf_wdata_o        = div_en_i ? div_hs.result : alu_result;
  assign branch_decision_o = alu_cmp;

  assign ex_ready_o = kill_i || (wb_ready_i && div_hs.ready && !halt_i);
  assign ex_valid_o = instr_valid && (alu_en_i || (div_en_i && div_hs.valid));

  // Towards EX/WB register
  assign res_o.valid     = ex_valid_o;
  assign res_o.rf_we     = rf_we_i;
  assign res_o.rf_waddr  = rf_waddr_i;
  assign res_o.rf_wdata  = rf_wdata_o;
  assign res_o.jmp       = jump_i && alu_en_i;
  assign res_o.bch_taken = branch_i && alu_en_i && alu_cmp;

endmodule

// File: ex_pkg.sv
// Execute stage shared definitions
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Operand and result width, default for the module parameter
  parameter int DATA_W = 32;

  // Register file address width
  parameter int RF_ADDR_W = 5;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // ALU operations, comparisons last so branches share the compare path
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  // Divider operations
  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_op_e;

  // Divider FSM states
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_BUSY = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

// File: ex_stage.sv
// Execute stage top
`timescale 1ns/1ps

module ex_stage #(
  parameter int DATA_W = ex_pkg::DATA_W
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Decoded instruction from ID
  input  logic                         id_valid_i,
  input  logic                         alu_en_i,
  input  logic                         div_en_i,
  input  ex_pkg::alu_op_e              alu_op_i,
  input  ex_pkg::div_op_e              div_op_i,
  input  logic [DATA_W-1:0]            operand_a_i,
  input  logic [DATA_W-1:0]            operand_b_i,
  input  logic                         branch_i,
  input  logic                         jump_i,
  input  logic                         rf_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] rf_waddr_i,
  // Controller
  input  logic                         kill_i,
  input  logic                         halt_i,
  // Back-pressure from WB
  input  logic                         wb_ready_i,
  // Stage handshake, branch and forwarding
  output logic                         ex_ready_o,
  output logic                         ex_valid_o,
  output logic                         branch_decision_o,
  output logic [DATA_W-1:0]            rf_wdata_o,
  // EX/WB register outputs
  output logic                         wb_valid_o,
  output logic                         wb_rf_we_o,
  output logic [ex_pkg::RF_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [DATA_W-1:0]            wb_rf_wdata_o,
  output logic                         wb_jmp_o,
  output logic                         wb_bch_taken_o
);

  ex_result_if #(.DATA_W(DATA_W)) ex_res ();

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  ex_issue #(.DATA_W(DATA_W)) u_issue (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_valid_i        (id_valid_i),
    .alu_en_i          (alu_en_i),
    .div_en_i          (div_en_i),
    .alu_op_i          (alu_op_i),
    .div_op_i          (div_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_i          (branch_i),
    .jump_i            (jump_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .rf_wdata_o        (rf_wdata_o),
    .res_o             (ex_res.issue)
  );

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////
  ex_wb_reg #(.DATA_W(DATA_W)) u_wb_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_ready_i     (wb_ready_i),
    .res_i          (ex_res.wb),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_jmp_o       (wb_jmp_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

// File: ex_wb_reg.sv
// EX/WB pipeline register
`timescale 1ns/1ps

module ex_wb_reg #(
  parameter int DATA_W = ex_pkg::DATA_W
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wb_ready_i,
  ex_result_if.wb                      res_i,
  output logic                         wb_valid_o,
  output logic                         wb_rf_we_o,
  output logic [ex_pkg::RF_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [DATA_W-1:0]            wb_rf_wdata_o,
  output logic                         wb_jmp_o,
  output logic                         wb_bch_taken_o
);

  logic capture;

  // Writeback takes a new entry only when it is ready
  assign capture = res_i.valid && wb_ready_i;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_jmp_o       <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (capture) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= res_i.rf_we;
      wb_jmp_o       <= res_i.jmp;
      wb_bch_taken_o <= res_i.bch_taken;
    end else if (wb_ready_i) begin
      // Nothing valid in EX, insert a bubble
      wb_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Write port payload
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    // Keep previous address and data when no register write
    if (capture && res_i.rf_we) begin
      wb_rf_waddr_o <= res_i.rf_waddr;
      wb_rf_wdata_o <= res_i.rf_wdata;
    end
  end

endmodule

// File: flist.f
ex_pkg.sv
ex_if.sv
ex_alu.sv
ex_div.sv
ex_issue.sv
ex_wb_reg.sv
ex_stage.sv
tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f flist.f -o sim_ex_stage

./obj_dir/sim_ex_stage | tee sim.log

# Pass only if the testbench printed its pass line
grep -q "^Simulation finished: PASS$" sim.log
echo "run.sh: passed"

// File: tb_ex_stage.sv
// Execute stage testbench
`timescale 1ns/1ps

module tb_ex_stage;
  import ex_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int N_ALU          = 300;
  localparam int N_DIV          = 60;
  localparam logic [31:0] MIN_INT = 32'h8000_0000;

  typedef struct packed {
    logic                 we;
    logic [RF_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]    data;
    logic                 jmp;
    logic                 bch;
  } wb_entry_t;

  logic clk;
  logic rst_n;
  logic id_valid_i, alu_en_i, div_en_i;
  alu_op_e alu_op_i;
  div_op_e div_op_i;
  logic [DATA_W-1:0] operand_a_i, operand_b_i;
  logic branch_i, jump_i, rf_we_i;
  logic [RF_ADDR_W-1:0] rf_waddr_i;
  logic kill_i, halt_i, wb_ready_i;
  logic ex_ready_o, ex_valid_o, branch_decision_o;
  logic [DATA_W-1:0] rf_wdata_o;
  logic wb_valid_o, wb_rf_we_o, wb_jmp_o, wb_bch_taken_o;
  logic [RF_ADDR_W-1:0] wb_rf_waddr_o;
  logic [DATA_W-1:0] wb_rf_wdata_o;

  // Scoreboard state
  wb_entry_t exp_q[$];
  int errors;
  int cycle_cnt;
  logic [DATA_W-1:0] exp_data;
  logic exp_cmp;
  logic cap_pend, ready_prev, captured;
  logic shadow_ok;
  logic [RF_ADDR_W-1:0] shadow_addr;
  logic [DATA_W-1:0] shadow_data;
  // Writeback outputs seen at the previous falling edge
  logic [DATA_W+RF_ADDR_W+3:0] snap;

  ex_stage #(.DATA_W(DATA_W)) uut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic cmp_model(input alu_op_e op, input logic [31:0] a, b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a, b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      // Sign bits shifted in from the top
      ALU_SRA: return a[31] ? ~(~a >> b[4:0]) : (a >> b[4:0]);
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  // Divide by zero and MIN / -1 follow the usual RISC-V results
  function automatic logic [31:0] div_model(input div_op_e op, input logic [31:0] a, b);
    logic ovf;
    ovf = (a == MIN_INT) && (b == 32'hFFFF_FFFF);
    case (op)
      DIV_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
      DIV_REMU: return (b == 0) ? a : a % b;
      DIV_DIV: begin
        if (b == 0) return 32'hFFFF_FFFF;
        if (ovf) return MIN_INT;
        return $unsigned($signed(a) / $signed(b));
      end
      default: begin
        if (b == 0) return a;
        if (ovf) return 32'h0;
        return $unsigned($signed(a) % $signed(b));
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic compare_hex(input string name, input logic [31:0] exp_v, act_v);
    assert (act_v === exp_v) else begin
      errors++;
      $display("** Error: %s expected 0x%08h actual 0x%08h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic require_true(input logic c, input string msg);
    assert (c === 1'b1) else begin
      errors++;
      $display("Check failed at %0t: %s", $time, msg);
    end
  endtask

  // Stage handshake rules checked at every rising edge
  halt_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    halt_i |-> !ex_valid_o) else begin
    errors++;
    $display("ex_valid_o was high while halt_i was high at %0t", $time);
  end

  kill_gives_ready: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> ex_ready_o) else begin
    errors++;
    $display("ex_ready_o was low while kill_i was high at %0t", $time);
  end

  task automatic take_snapshot();
    snap = {wb_valid_o, wb_rf_we_o, wb_jmp_o, wb_bch_taken_o, wb_rf_waddr_o, wb_rf_wdata_o};
  endtask

  // Writeback side sampled at the falling edge
  task automatic score_writeback();
    wb_entry_t e;
    if (ready_prev) begin
      if (wb_valid_o) begin
        // Register took a new entry at the last edge
        if (exp_q.size() == 0) begin
          require_true(1'b0, "writeback result without an expected entry");
        end else begin
          e = exp_q.pop_front();
          compare_hex("wb_rf_we_o", {31'b0, e.we}, {31'b0, wb_rf_we_o});
          compare_hex("wb_jmp_o", {31'b0, e.jmp}, {31'b0, wb_jmp_o});
          compare_hex("wb_bch_taken_o", {31'b0, e.bch}, {31'b0, wb_bch_taken_o});
          if (e.we) begin
            shadow_ok   = 1'b1;
            shadow_addr = e.addr;
            shadow_data = e.data;
          end
          if (shadow_ok) begin
            compare_hex("wb_rf_waddr_o", {27'b0, shadow_addr}, {27'b0, wb_rf_waddr_o});
            compare_hex("wb_rf_wdata_o", shadow_data, wb_rf_wdata_o);
          end
        end
      end else begin
        require_true(!cap_pend, "captured instruction missing at writeback");
      end
    end else begin
      // Stall holds every output
      require_true(snap === {wb_valid_o, wb_rf_we_o, wb_jmp_o, wb_bch_taken_o,
                             wb_rf_waddr_o, wb_rf_wdata_o},
                   "writeback outputs changed during stall");
    end
    take_snapshot();
  endtask

  // One clock with inputs already driven at the falling edge
  task automatic clock_cycle();
    #1;
    if (id_valid_i && !kill_i && !halt_i) begin
      if (alu_en_i) begin
        require_true(ex_valid_o, "ex_valid_o low for a valid ALU instruction");
        compare_hex("rf_wdata_o", exp_data, rf_wdata_o);
        compare_hex("branch_decision_o", {31'b0, exp_cmp}, {31'b0, branch_decision_o});
      end else if (div_en_i) begin
        if (ex_valid_o) compare_hex("rf_wdata_o", exp_data, rf_wdata_o);
        else require_true(!ex_ready_o, "ex_ready_o high while divide in progress");
      end
    end
    cap_pend   = ex_valid_o && wb_ready_i;
    ready_prev = wb_ready_i;
    if (cap_pend) begin
      exp_q.push_back({rf_we_i, rf_waddr_i, exp_data, jump_i && alu_en_i,
                       branch_i && alu_en_i && exp_cmp});
      captured = 1'b1;
    end
    @(negedge clk);
    score_writeback();
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic setup_instr(input logic is_div, input logic safe_b);
    int pick;
    pick        = $urandom_range(0, 7);
    id_valid_i  = 1'b1;
    alu_en_i    = !is_div;
    div_en_i    = is_div;
    alu_op_i    = alu_op_e'($urandom_range(0, 15));
    div_op_i    = div_op_e'($urandom_range(0, 3));
    operand_a_i = $urandom();
    operand_b_i = (pick == 1) ? operand_a_i : $urandom();
    if (is_div && pick == 0) operand_b_i = '0;
    if (is_div && pick == 2) begin
      operand_a_i = MIN_INT;
      operand_b_i = 32'hFFFF_FFFF;
    end
    // Small divisors give nonzero quotients more often
    if (is_div && pick == 3) operand_b_i = 32'($urandom_range(1, 100));
    if (safe_b) operand_b_i = operand_b_i | 32'h1;
    branch_i   = $urandom_range(0, 1);
    jump_i     = $urandom_range(0, 1);
    rf_we_i    = ($urandom_range(0, 3) != 0);
    rf_waddr_i = 5'($urandom_range(0, 31));
    exp_cmp    = cmp_model(alu_op_i, operand_a_i, operand_b_i);
    exp_data   = is_div ? div_model(div_op_i, operand_a_i, operand_b_i)
                        : alu_model(alu_op_i, operand_a_i, operand_b_i);
    captured   = 1'b0;
  endtask

  task automatic run_op(input logic is_div);
    setup_instr(is_div, 1'b0);
    while (!captured) begin
      wb_ready_i = ($urandom_range(0, 4) != 0);
      halt_i     = ($urandom_range(0, 9) == 0);
      clock_cycle();
    end
    halt_i = 1'b0;
  endtask

  // Kill an ALU instruction at once or a divide in progress
  task automatic kill_op(input logic is_div);
    setup_instr(is_div, 1'b1);
    wb_ready_i = 1'b1;
    halt_i     = 1'b0;
    repeat (is_div ? $urandom_range(1, 8) : 0) clock_cycle();
    kill_i = 1'b1;
    clock_cycle();
    kill_i     = 1'b0;
    id_valid_i = 1'b0;
    alu_en_i   = 1'b0;
    div_en_i   = 1'b0;
    clock_cycle();
    require_true(!captured, "killed instruction reached writeback");
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, errors: %0d", cycle_cnt, errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32294));
    errors = 0;
    cycle_cnt = 0;
    rst_n = 1'b0;
    {id_valid_i, alu_en_i, div_en_i, branch_i, jump_i, rf_we_i} = '0;
    alu_op_i = ALU_ADD;
    div_op_i = DIV_DIV;
    {operand_a_i, operand_b_i, rf_waddr_i} = '0;
    {kill_i, halt_i} = '0;
    wb_ready_i = 1'b1;
    {cap_pend, ready_prev, captured, shadow_ok, exp_cmp} = '0;
    exp_data = '0;
    repeat (10) begin
      @(negedge clk);
      require_true(!wb_valid_o && !wb_rf_we_o, "writeback not idle during reset");
    end
    take_snapshot();
    rst_n = 1'b1;
    clock_cycle();
    require_true(!wb_rf_we_o, "wb_rf_we_o high at first edge after reset");

    for (int i = 0; i < N_ALU + N_DIV; i++) begin
      run_op(i % 6 == 5);
      if (i % 20 == 10) kill_op(i % 40 == 10);
    end

    id_valid_i = 1'b0;
    alu_en_i   = 1'b0;
    div_en_i   = 1'b0;
    wb_ready_i = 1'b1;
    repeat (2) clock_cycle();
    require_true(exp_q.size() == 0, "expected results never reached writeback");

    $display("Errors: %0d, cycles: %0d", errors, cycle_cnt);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
